//--- Bender.yml
package:
  name: md_unit

sources:
  - source/muldiv_pkg.sv
  - source/md_multiplier.sv
  - source/md_divider.sv
  - source/md_hilo.sv
  - source/md_control.sv
  - source/md_unit.sv
  - target: simulation
    files:
      - sim/tb_md_unit.sv

//--- sim/tb_md_unit.sv
`timescale 1ns/1ps

module tb_md_unit;

	// One table row whose random flag replaces both operands
	typedef struct packed {
		muldiv_pkg::md_op_e op;
		muldiv_pkg::word_t  rs;
		muldiv_pkg::word_t  rt;
		logic               rnd;
	} entry_t;

	localparam int wait_limit = 64;

	logic                clk;
	logic                rst_n;
	logic                req_valid;
	muldiv_pkg::md_req_t req;
	logic                res_valid;
	muldiv_pkg::md_res_t res;
	logic                busy;

	entry_t              tests[$];
	muldiv_pkg::word_t   res_q[$];
	muldiv_pkg::word_t   hi_m;
	muldiv_pkg::word_t   lo_m;
	logic [31:0]         lfsr_q;
	int                  test_errors;
	int                  total_errors;
	int                  tests_failed;

	md_unit u_md_unit (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req       (req),
		.res_valid (res_valid),
		.res       (res),
		.busy      (busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Results captured mid-cycle in arrival order
	always @(negedge clk)
	begin
		if (rst_n && res_valid)
			res_q.push_back(res.data);
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model and random source
	////////////////////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_word(output muldiv_pkg::word_t w);
		for (int i = 0; i < 32; i++)
		begin
			lfsr_q = lfsr_next(lfsr_q);
			w = {w[30:0], lfsr_q[0]};
		end
	endtask

	// Full 64-bit product of operands extended by mode
	function automatic muldiv_pkg::dword_t mul_model(input muldiv_pkg::word_t a,
		input muldiv_pkg::word_t b, input logic sgn);
		muldiv_pkg::dword_t ax;
		muldiv_pkg::dword_t bx;
		ax = sgn ? {{32{a[31]}}, a} : {32'd0, a};
		bx = sgn ? {{32{b[31]}}, b} : {32'd0, b};
		return ax * bx;
	endfunction

	// Returns {remainder, quotient}
	function automatic muldiv_pkg::dword_t div_model(input muldiv_pkg::word_t a,
		input muldiv_pkg::word_t b, input logic sgn);
		longint            sa;
		longint            sb;
		muldiv_pkg::word_t q;
		muldiv_pkg::word_t r;
		if (b == 32'd0)
		begin
			// All-ones magnitude negated when the dividend is negative
			q = (sgn && a[31]) ? 32'd1 : 32'hffff_ffff;
			r = a;
		end
		else if (sgn)
		begin
			// Wide enough that the most negative value cannot overflow
			sa = $signed(a);
			sb = $signed(b);
			q = sa / sb;
			r = sa % sb;
		end
		else
		begin
			q = a / b;
			r = a % b;
		end
		return {r, q};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks and bus tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic finish_run;
		$display("Tests run %0d, tests failed %0d, checks failed %0d",
			tests.size() + 1, tests_failed, total_errors);
		if (total_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	endtask

	task automatic timeout(input string what);
		$display("Timeout after %0d cycles waiting for %s", wait_limit, what);
		total_errors++;
		tests_failed++;
		finish_run();
	endtask

	task automatic check_word(input string name, input muldiv_pkg::word_t exp,
		input muldiv_pkg::word_t got);
		assert (got === exp)
		else
		begin
			$display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, got);
			test_errors++;
			total_errors++;
		end
	endtask

	// Called at posedge + 1 and returns 1 ns after the accepting edge
	task automatic send(input muldiv_pkg::md_op_e op, input muldiv_pkg::word_t rs,
		input muldiv_pkg::word_t rt);
		int n;
		n = 0;
		req_valid = 1'b1;
		req.op = op;
		req.rs = rs;
		req.rt = rt;
		#1;
		while (busy && n < wait_limit)
		begin
			@(posedge clk);
			#2;
			n++;
		end
		if (busy)
			timeout("busy to fall");
		@(posedge clk);
		#1;
		req_valid = 1'b0;
		req.op = muldiv_pkg::MD_NOP;
	endtask

	task automatic wait_results(input int count);
		int n;
		n = 0;
		while (res_q.size() < count && n < wait_limit)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (res_q.size() < count)
			timeout("res_valid");
	endtask

	task automatic read_reg(input muldiv_pkg::md_op_e op, output muldiv_pkg::word_t val);
		send(op, '0, '0);
		wait_results(1);
		val = res_q.pop_front();
	endtask

	// LO first so that a read right after MULT sits on the stall
	task automatic readback;
		muldiv_pkg::word_t v;
		read_reg(muldiv_pkg::MD_MFLO, v);
		check_word("res.data (LO)", lo_m, v);
		read_reg(muldiv_pkg::MD_MFHI, v);
		check_word("res.data (HI)", hi_m, v);
	endtask

	// MTHI strobed into a running division must be dropped
	task automatic drop_during_busy(input muldiv_pkg::word_t v);
		req_valid = 1'b1;
		req.op = muldiv_pkg::MD_MTHI;
		req.rs = v;
		req.rt = '0;
		#1;
		assert (busy)
		else
		begin
			$display("MTHI during a division was not stalled, busy was low");
			test_errors++;
			total_errors++;
		end
		@(posedge clk);
		#1;
		req_valid = 1'b0;
		req.op = muldiv_pkg::MD_NOP;
	endtask

	// Three back-to-back MULs with results expected in issue order
	task automatic mul_burst(input muldiv_pkg::word_t a, input muldiv_pkg::word_t b);
		muldiv_pkg::word_t  ra[3];
		muldiv_pkg::word_t  rb[3];
		muldiv_pkg::dword_t p;
		muldiv_pkg::word_t  v;
		ra = '{a, ~a, a};
		rb = '{b, b, ~b};
		for (int i = 0; i < 3; i++)
			send(muldiv_pkg::MD_MUL, ra[i], rb[i]);
		wait_results(3);
		for (int i = 0; i < 3; i++)
		begin
			p = mul_model(ra[i], rb[i], 1'b1);
			v = res_q.pop_front();
			check_word("res.data (MUL)", p[31:0], v);
		end
	endtask

	task automatic add(input muldiv_pkg::md_op_e op, input muldiv_pkg::word_t rs,
		input muldiv_pkg::word_t rt, input logic rnd);
		tests.push_back('{op, rs, rt, rnd});
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		entry_t e;
		rst_n = 1'b0;
		req_valid = 1'b0;
		req = '0;
		lfsr_q = 32'd72807;
		hi_m = '0;
		lo_m = '0;
		test_errors = 0;
		total_errors = 0;
		tests_failed = 0;

		// Reset readback and move ops
		add(muldiv_pkg::MD_MFHI, 32'h0, 32'h0, 1'b0);
		add(muldiv_pkg::MD_MTHI, 32'h1234_5678, 32'h0, 1'b0);
		add(muldiv_pkg::MD_MTLO, 32'h9abc_def0, 32'h0, 1'b0);
		// Multiply corners
		add(muldiv_pkg::MD_MULT, 32'h0, 32'h7fff_ffff, 1'b0);
		add(muldiv_pkg::MD_MULT, 32'h1, 32'hffff_ffff, 1'b0);
		add(muldiv_pkg::MD_MULT, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
		add(muldiv_pkg::MD_MULT, 32'h8000_0000, 32'h8000_0000, 1'b0);
		add(muldiv_pkg::MD_MULT, 32'h8000_0000, 32'hffff_ffff, 1'b0);
		add(muldiv_pkg::MD_MULTU, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
		add(muldiv_pkg::MD_MULTU, 32'h8000_0000, 32'h2, 1'b0);
		add(muldiv_pkg::MD_MULT, 32'h0, 32'h0, 1'b1);
		add(muldiv_pkg::MD_MULTU, 32'h0, 32'h0, 1'b1);
		// Pipelined MUL bursts
		add(muldiv_pkg::MD_MUL, 32'h3, 32'h5, 1'b0);
		add(muldiv_pkg::MD_MUL, 32'h0, 32'h0, 1'b1);
		// Division sign cases and corners
		add(muldiv_pkg::MD_DIV, 32'd100, 32'd7, 1'b0);
		add(muldiv_pkg::MD_DIV, -32'sd100, 32'd7, 1'b0);
		add(muldiv_pkg::MD_DIV, 32'd100, -32'sd7, 1'b0);
		add(muldiv_pkg::MD_DIV, -32'sd100, -32'sd7, 1'b0);
		add(muldiv_pkg::MD_DIVU, 32'hffff_ff9c, 32'd7, 1'b0);
		add(muldiv_pkg::MD_DIV, 32'h8000_0000, 32'hffff_ffff, 1'b0);
		add(muldiv_pkg::MD_DIV, 32'h0, 32'h0, 1'b1);
		add(muldiv_pkg::MD_DIVU, 32'h0, 32'h0, 1'b1);
		// Divide by zero
		add(muldiv_pkg::MD_DIV, -32'sd100, 32'd0, 1'b0);
		add(muldiv_pkg::MD_DIVU, 32'd12345, 32'd0, 1'b0);
		add(muldiv_pkg::MD_MULT, 32'h0, 32'h0, 1'b1);

		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		#1;
		assert (!busy && !res_valid)
		else
		begin
			$display("busy or res_valid high after reset");
			test_errors++;
			total_errors++;
		end
		@(posedge clk);
		#1;
		$display("Test  0 reset: %0d error(s)", test_errors);
		if (test_errors != 0)
			tests_failed++;

		foreach (tests[i])
		begin
			e = tests[i];
			test_errors = 0;
			if (e.rnd)
			begin
				rand_word(e.rs);
				rand_word(e.rt);
			end
			case (e.op)
				muldiv_pkg::MD_MTHI:
				begin
					send(e.op, e.rs, e.rt);
					hi_m = e.rs;
				end
				muldiv_pkg::MD_MTLO:
				begin
					send(e.op, e.rs, e.rt);
					lo_m = e.rs;
				end
				muldiv_pkg::MD_MULT, muldiv_pkg::MD_MULTU:
				begin
					send(e.op, e.rs, e.rt);
					{hi_m, lo_m} = mul_model(e.rs, e.rt, e.op == muldiv_pkg::MD_MULT);
				end
				muldiv_pkg::MD_DIV, muldiv_pkg::MD_DIVU:
				begin
					send(e.op, e.rs, e.rt);
					drop_during_busy(e.rs ^ 32'h5a5a_5a5a);
					{hi_m, lo_m} = div_model(e.rs, e.rt, e.op == muldiv_pkg::MD_DIV);
				end
				muldiv_pkg::MD_MUL:
					mul_burst(e.rs, e.rt);
				default:
					;
			endcase
			// HI/LO checked after every row since MUL must leave them alone
			readback();
			assert (res_q.size() == 0)
			else
			begin
				$display("Unexpected extra result on the result port");
				test_errors++;
				total_errors++;
			end
			$display("Test %2d %-8s rs %h rt %h: %0d error(s)", i + 1, e.op.name(),
				e.rs, e.rt, test_errors);
			if (test_errors != 0)
				tests_failed++;
		end
		finish_run();
	end

endmodule

//--- source/md_control.sv
`timescale 1ns/1ps

module md_control (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  req_valid,
	input  muldiv_pkg::md_req_t   req,
	input  logic                  mul_done,
	input  muldiv_pkg::mul_dest_e mul_dest,
	input  logic                  div_done,
	output logic                  busy,
	output logic                  mul_start,
	output logic                  div_start,
	output logic                  signed_mode,
	output muldiv_pkg::mul_dest_e mul_dest_sel,
	output logic                  wr_hi,
	output logic                  wr_lo,
	output logic                  rd_hi,
	output logic                  rd_lo
);

	logic       accept;
	logic       is_mul;
	logic       is_mult;
	logic       is_div;
	logic       is_read;
	logic       hilo_pend_q;
	logic [1:0] mul_rec_q;

	//////////////////////////////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////////////////////////////

	assign is_mul  = (req.op == muldiv_pkg::MD_MUL);
	assign is_mult = (req.op == muldiv_pkg::MD_MULT) || (req.op == muldiv_pkg::MD_MULTU);
	assign is_div  = (req.op == muldiv_pkg::MD_DIV) || (req.op == muldiv_pkg::MD_DIVU);
	assign is_read = (req.op == muldiv_pkg::MD_MFHI) || (req.op == muldiv_pkg::MD_MFLO);

	// Pending HI/LO write, or a read that could meet a MUL result
	assign busy   = hilo_pend_q || (req_valid && is_read && (mul_rec_q != 2'b00));
	assign accept = req_valid && !busy;

	// One dispatch strobe per accepted op
	assign mul_start = accept && (is_mul || is_mult);
	assign div_start = accept && is_div;
	assign wr_hi     = accept && (req.op == muldiv_pkg::MD_MTHI);
	assign wr_lo     = accept && (req.op == muldiv_pkg::MD_MTLO);
	assign rd_hi     = accept && (req.op == muldiv_pkg::MD_MFHI);
	assign rd_lo     = accept && (req.op == muldiv_pkg::MD_MFLO);

	// Signed ops
	assign signed_mode = (req.op == muldiv_pkg::MD_DIV)
		|| (req.op == muldiv_pkg::MD_MULT)
		|| (req.op == muldiv_pkg::MD_MUL);

	assign mul_dest_sel = is_mul ? muldiv_pkg::MUL_TO_GPR : muldiv_pkg::MUL_TO_HILO;

	//////////////////////////////////////////////////////////////////////////
	// Stall tracking
	//////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hilo_pend_q <= 1'b0;
			mul_rec_q   <= 2'b00;
		end
		else
		begin
			// Cleared when the update lands in HI/LO
			if (div_done || (mul_done && (mul_dest == muldiv_pkg::MUL_TO_HILO)))
				hilo_pend_q <= 1'b0;
			else if (accept && (is_mult || is_div))
				hilo_pend_q <= 1'b1;
			// One bit per multiplier stage
			mul_rec_q <= {mul_rec_q[0], accept && is_mul};
		end
	end

endmodule

//--- source/md_divider.sv
`timescale 1ns/1ps

module md_divider (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              div_start,
	input  muldiv_pkg::word_t dividend,
	input  muldiv_pkg::word_t divisor,
	input  logic              signed_mode,
	output logic              div_done,
	output muldiv_pkg::word_t quotient,
	output muldiv_pkg::word_t remainder
);

	muldiv_pkg::div_state_e state_q;
	logic [4:0]             step_q;
	muldiv_pkg::word_t      dvd_mag;
	muldiv_pkg::word_t      dvs_mag;
	muldiv_pkg::word_t      dvs_q;
	muldiv_pkg::word_t      rem_q;
	muldiv_pkg::word_t      quo_q;
	logic                   q_neg_q;
	logic                   r_neg_q;
	logic [32:0]            rem_shift;
	logic [33:0]            trial;
	logic                   load;

	// Operand magnitudes for the unsigned core
	assign dvd_mag = (signed_mode && dividend[31]) ? -dividend : dividend;
	assign dvs_mag = (signed_mode && divisor[31]) ? -divisor : divisor;

	assign load = (state_q == muldiv_pkg::DIV_IDLE) && div_start;

	//////////////////////////////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state_q <= muldiv_pkg::DIV_IDLE;
			step_q  <= 5'd0;
		end
		else
		begin
			case (state_q)
				muldiv_pkg::DIV_IDLE:
				begin
					step_q <= 5'd0;
					if (div_start)
						state_q <= muldiv_pkg::DIV_RUN;
				end
				muldiv_pkg::DIV_RUN:
				begin
					step_q <= step_q + 5'd1;
					// Last of 32 quotient bits
					if (step_q == 5'd31)
						state_q <= muldiv_pkg::DIV_FIX;
				end
				muldiv_pkg::DIV_FIX:
					state_q <= muldiv_pkg::DIV_IDLE;
				default:
					state_q <= muldiv_pkg::DIV_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// Restoring shift-subtract datapath
	//////////////////////////////////////////////////////////////////////////

	// Next dividend bit enters from the top of the quotient register
	assign rem_shift = {rem_q, quo_q[31]};
	// Borrow in bit 33 means restore
	assign trial = {1'b0, rem_shift} - {2'b00, dvs_q};

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			dvs_q   <= dvs_mag;
			quo_q   <= dvd_mag;
			rem_q   <= '0;
			q_neg_q <= signed_mode && (dividend[31] ^ divisor[31]);
			r_neg_q <= signed_mode && dividend[31];
		end
		else if (state_q == muldiv_pkg::DIV_RUN)
		begin
			if (!trial[33])
				rem_q <= trial[31:0];
			else
				rem_q <= rem_shift[31:0];
			quo_q <= {quo_q[30:0], !trial[33]};
		end
	end

	// Sign fix during the final cycle
	assign div_done  = (state_q == muldiv_pkg::DIV_FIX);
	assign quotient  = q_neg_q ? -quo_q : quo_q;
	assign remainder = r_neg_q ? -rem_q : rem_q;

endmodule

//--- source/md_hilo.sv
`timescale 1ns/1ps

module md_hilo (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  wr_hi,
	input  logic                  wr_lo,
	input  muldiv_pkg::word_t     wr_data,
	input  logic                  rd_hi,
	input  logic                  rd_lo,
	input  logic                  mul_done,
	input  muldiv_pkg::mul_dest_e mul_dest,
	input  muldiv_pkg::dword_t    product,
	input  logic                  div_done,
	input  muldiv_pkg::word_t     quotient,
	input  muldiv_pkg::word_t     remainder,
	output logic                  res_valid,
	output muldiv_pkg::md_res_t   res
);

	muldiv_pkg::word_t hi_q;
	muldiv_pkg::word_t lo_q;
	logic              mul_gpr;

	assign mul_gpr = mul_done && (mul_dest == muldiv_pkg::MUL_TO_GPR);

	// HI and LO with at most one write source per cycle
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hi_q <= '0;
			lo_q <= '0;
		end
		else if (div_done)
		begin
			// Remainder to HI, quotient to LO
			hi_q <= remainder;
			lo_q <= quotient;
		end
		else if (mul_done && (mul_dest == muldiv_pkg::MUL_TO_HILO))
		begin
			{hi_q, lo_q} <= product;
		end
		else
		begin
			if (wr_hi)
				hi_q <= wr_data;
			if (wr_lo)
				lo_q <= wr_data;
		end
	end

	// Result strobe
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			res_valid <= 1'b0;
		else
			res_valid <= rd_hi || rd_lo || mul_gpr;
	end

	// Result word from a move-from or a MUL low word
	always_ff @(posedge clk)
	begin
		if (rd_hi)
			res.data <= hi_q;
		else if (rd_lo)
			res.data <= lo_q;
		else if (mul_gpr)
			res.data <= product[31:0];
	end

endmodule

//--- source/md_multiplier.sv
`timescale 1ns/1ps

module md_multiplier (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  mul_start,
	input  muldiv_pkg::word_t     a_in,
	input  muldiv_pkg::word_t     b_in,
	input  logic                  signed_mode,
	input  muldiv_pkg::mul_dest_e dest,
	output logic                  mul_done,
	output muldiv_pkg::mul_dest_e mul_dest,
	output muldiv_pkg::dword_t    product
);

	// Stage one payload of four 16x16 partials and the result sign
	typedef struct packed {
		muldiv_pkg::word_t ll;
		muldiv_pkg::word_t lh;
		muldiv_pkg::word_t hl;
		muldiv_pkg::word_t hh;
		logic              neg;
	} pp_t;

	muldiv_pkg::word_t     a_mag;
	muldiv_pkg::word_t     b_mag;
	pp_t                   pp_d;
	pp_t                   pp_q;
	logic                  s1_valid_q;
	muldiv_pkg::mul_dest_e s1_dest_q;
	muldiv_pkg::dword_t    sum;

	//////////////////////////////////////////////////////////////////////////
	// Stage one
	//////////////////////////////////////////////////////////////////////////

	// Operand magnitudes with negation only in signed mode
	assign a_mag = (signed_mode && a_in[31]) ? -a_in : a_in;
	assign b_mag = (signed_mode && b_in[31]) ? -b_in : b_in;

	assign pp_d.ll  = a_mag[15:0] * b_mag[15:0];
	assign pp_d.lh  = a_mag[15:0] * b_mag[31:16];
	assign pp_d.hl  = a_mag[31:16] * b_mag[15:0];
	assign pp_d.hh  = a_mag[31:16] * b_mag[31:16];
	// Product negative when operand signs differ
	assign pp_d.neg = signed_mode && (a_in[31] ^ b_in[31]);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s1_valid_q <= 1'b0;
			s1_dest_q  <= muldiv_pkg::MUL_TO_GPR;
		end
		else
		begin
			s1_valid_q <= mul_start;
			s1_dest_q  <= dest;
		end
	end

	always_ff @(posedge clk)
	begin
		pp_q <= pp_d;
	end

	//////////////////////////////////////////////////////////////////////////
	// Stage two
	//////////////////////////////////////////////////////////////////////////

	// Align and add the partials
	assign sum = {32'd0, pp_q.ll}
		+ {16'd0, pp_q.lh, 16'd0}
		+ {16'd0, pp_q.hl, 16'd0}
		+ {pp_q.hh, 32'd0};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mul_done <= 1'b0;
			mul_dest <= muldiv_pkg::MUL_TO_GPR;
		end
		else
		begin
			mul_done <= s1_valid_q;
			mul_dest <= s1_dest_q;
		end
	end

	always_ff @(posedge clk)
	begin
		product <= pp_q.neg ? -sum : sum;
	end

endmodule

//--- source/md_unit.sv
`timescale 1ns/1ps

module md_unit (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                req_valid,
	input  muldiv_pkg::md_req_t req,
	output logic                res_valid,
	output muldiv_pkg::md_res_t res,
	output logic                busy
);

	logic                  mul_start;
	logic                  div_start;
	logic                  signed_mode;
	muldiv_pkg::mul_dest_e mul_dest_sel;
	logic                  wr_hi;
	logic                  wr_lo;
	logic                  rd_hi;
	logic                  rd_lo;
	logic                  mul_done;
	muldiv_pkg::mul_dest_e mul_dest;
	muldiv_pkg::dword_t    product;
	logic                  div_done;
	muldiv_pkg::word_t     quotient;
	muldiv_pkg::word_t     remainder;

	// Decode, dispatch and stall
	md_control u_md_control (
		.clk          (clk),
		.rst_n        (rst_n),
		.req_valid    (req_valid),
		.req          (req),
		.mul_done     (mul_done),
		.mul_dest     (mul_dest),
		.div_done     (div_done),
		.busy         (busy),
		.mul_start    (mul_start),
		.div_start    (div_start),
		.signed_mode  (signed_mode),
		.mul_dest_sel (mul_dest_sel),
		.wr_hi        (wr_hi),
		.wr_lo        (wr_lo),
		.rd_hi        (rd_hi),
		.rd_lo        (rd_lo)
	);

	// Operands straight from the request
	md_multiplier u_md_multiplier (
		.clk         (clk),
		.rst_n       (rst_n),
		.mul_start   (mul_start),
		.a_in        (req.rs),
		.b_in        (req.rt),
		.signed_mode (signed_mode),
		.dest        (mul_dest_sel),
		.mul_done    (mul_done),
		.mul_dest    (mul_dest),
		.product     (product)
	);

	md_divider u_md_divider (
		.clk         (clk),
		.rst_n       (rst_n),
		.div_start   (div_start),
		.dividend    (req.rs),
		.divisor     (req.rt),
		.signed_mode (signed_mode),
		.div_done    (div_done),
		.quotient    (quotient),
		.remainder   (remainder)
	);

	// HI/LO file and result port
	md_hilo u_md_hilo (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_hi     (wr_hi),
		.wr_lo     (wr_lo),
		.wr_data   (req.rs),
		.rd_hi     (rd_hi),
		.rd_lo     (rd_lo),
		.mul_done  (mul_done),
		.mul_dest  (mul_dest),
		.product   (product),
		.div_done  (div_done),
		.quotient  (quotient),
		.remainder (remainder),
		.res_valid (res_valid),
		.res       (res)
	);

endmodule

//--- source/muldiv_pkg.sv
package muldiv_pkg;

	// General purpose register value
	typedef logic [31:0] word_t;

	// Full product or HI:LO pair
	typedef logic [63:0] dword_t;

	// Operation codes in the numbering of the decode stage
	typedef enum logic [3:0] {
		MD_NOP   = 4'd0,
		MD_DIV   = 4'd1,
		MD_DIVU  = 4'd2,
		MD_MFHI  = 4'd3,
		MD_MFLO  = 4'd4,
		MD_MTHI  = 4'd5,
		MD_MTLO  = 4'd6,
		MD_MUL   = 4'd7,
		MD_MULT  = 4'd8,
		MD_MULTU = 4'd9
	} md_op_e;

	// One issued operation with both source operands
	typedef struct packed {
		md_op_e op;
		word_t  rs;
		word_t  rt;
	} md_req_t;

	// Word returned to the register file
	typedef struct packed {
		word_t data;
	} md_res_t;

	// Where a finished product goes
	typedef enum logic {
		MUL_TO_GPR  = 1'b0,
		MUL_TO_HILO = 1'b1
	} mul_dest_e;

	// Divider sequencing
	typedef enum logic [1:0] {
		DIV_IDLE = 2'd0,
		DIV_RUN  = 2'd1,
		DIV_FIX  = 2'd2
	} div_state_e;

endpackage

//--- verilog.f
source/muldiv_pkg.sv
source/md_multiplier.sv
source/md_divider.sv
source/md_hilo.sv
source/md_control.sv
source/md_unit.sv
sim/tb_md_unit.sv
